/* gearbox_stimulus.txt */
// Columns: up_vld_in down_rdy hold_cycles
// Each line is driven for hold_cycles clock cycles, values in decimal
0 1 6
1 1 20
1 0 10
1 1 8
0 0 6
0 1 6
1 0 3
1 1 1
1 0 4
1 1 2
0 1 5
1 1 24
1 0 1
1 1 1
1 0 2
1 1 3
0 1 4
1 1 16
1 0 7
1 1 12
0 1 8

/* list.f */
+incdir+.
gearbox_pkg.sv
pattern_source.sv
gearbox_ctrl.sv
gearbox_datapath.sv
display_scan_timer.sv
seven_segment_display.sv
gearbox_top.sv
tb_checker.sv
tb_gearbox.sv

/* Bender.yml */
package:
  name: gearbox

sources:
  - include_dirs:
      - .
    files:
      - gearbox_pkg.sv
      - pattern_source.sv
      - gearbox_ctrl.sv
      - gearbox_datapath.sv
      - display_scan_timer.sv
      - seven_segment_display.sv
      - gearbox_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_checker.sv
      - tb_gearbox.sv

/* tb_gearbox.sv */
`default_nettype none

`include "gearbox_cfg.svh"

module tb_gearbox;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          RANDOM_CYCLES = 150;
    localparam logic [31:0] SEED          = 32'h1e05c3e3;

    logic                        clk;
    logic                        reset;
    logic                        up_vld_in;
    logic                        down_rdy;
    logic                        up_vld;
    logic                        up_rdy;
    logic [2*`GEARBOX_WIDTH-1:0] up_data;
    logic                        down_vld;
    logic [`GEARBOX_WIDTH-1:0]   down_data;
    logic [7:0]                  abcdefgh;
    logic [`GEARBOX_DIGITS-1:0]  digit;

    int errors;
    int checks;
    int words;
    int pending;
    int local_errors;
    int cycle_count;
    int cycle_limit;

    // Steps from the stimulus file
    int step_vld [$];
    int step_rdy [$];
    int step_hold [$];

    gearbox_top i_dut (.*);

    tb_checker i_checker (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles: %0d checks, %0d errors",
                     cycle_count, checks, errors + local_errors);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic read_stimulus(output int total);
        int    fd;
        int    n;
        int    v;
        int    r;
        int    h;
        string line;
        total = 0;
        fd = $fopen("gearbox_stimulus.txt", "r");
        if (fd == 0) begin
            local_errors++;
            $display("Could not open the stimulus file gearbox_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0) begin
                    // Comment and blank lines do not parse as three numbers
                    n = $sscanf(line, "%d %d %d", v, r, h);
                    if (n == 3) begin
                        step_vld.push_back(v);
                        step_rdy.push_back(r);
                        step_hold.push_back(h);
                        total += h;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        int hold_total;
        void'($urandom(SEED));
        reset     = 1'b1;
        up_vld_in = 1'b0;
        down_rdy  = 1'b0;
        read_stimulus(hold_total);
        cycle_limit = hold_total + RANDOM_CYCLES + 200;

        repeat (4) @(posedge clk);
        reset <= 1'b0;

        foreach (step_hold[i]) begin
            up_vld_in <= (step_vld[i] != 0);
            down_rdy  <= (step_rdy[i] != 0);
            repeat (step_hold[i]) @(posedge clk);
        end

        // Random stall phase with a steady upstream offer
        up_vld_in <= 1'b1;
        repeat (RANDOM_CYCLES) begin
            down_rdy <= 1'($urandom);
            @(posedge clk);
        end

        // Drain whatever is still in the gearbox
        up_vld_in <= 1'b0;
        down_rdy  <= 1'b1;
        @(negedge clk);
        while (down_vld)
            @(negedge clk);
        repeat (4) @(negedge clk);
        @(posedge clk);

        if (pending != 0) begin
            local_errors++;
            $display("Stream ended with %0d nibbles never delivered", pending);
        end
        if (words == 0) begin
            local_errors++;
            $display("No upstream word was transferred");
        end
        $display("Checks: %0d, upstream words: %0d, errors: %0d",
                 checks, words, errors + local_errors);
        if (errors + local_errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* tb_checker.sv */
`default_nettype none

`include "gearbox_cfg.svh"

module tb_checker (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       up_vld,
    input  logic                       up_rdy,
    input  gearbox_pkg::gear_word_u    up_data,
    input  logic                       down_vld,
    input  logic                       down_rdy,
    input  logic [`GEARBOX_WIDTH-1:0]  down_data,
    input  logic [7:0]                 abcdefgh,
    input  logic [`GEARBOX_DIGITS-1:0] digit,
    output int                         errors,
    output int                         checks,
    output int                         words,
    output int                         pending
);

    timeunit 1ns;
    timeprecision 1ps;

    import gearbox_pkg::*;

    // Nibbles accepted upstream and still waiting to go downstream
    logic [`GEARBOX_WIDTH-1:0] expect_q [$];
    logic [3:0]                model_index;
    logic                      stall_q;
    logic [`GEARBOX_WIDTH-1:0] stall_data;

    // Expected digit position and cycles spent on it
    int                        ref_digit;
    int                        ref_cnt;

    initial begin
        errors  = 0;
        checks  = 0;
        words   = 0;
        pending = 0;
    end

    task automatic check_value(string name, logic [7:0] got, logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // Display contents for the selected digit
    function automatic logic [7:0] expected_segments();
        if (digit[7])
            return segment_table[up_data.nib.hi] | {7'd0, up_vld};
        else if (digit[6])
            return segment_table[up_data.nib.lo] | {7'd0, up_vld};
        else if (digit[1])
            return 8'h00;
        else if (digit[0])
            return down_vld ? segment_table[down_data] : 8'h00;
        else
            return segment_table[0];
    endfunction

    // ------------------------------------------------------------------------
    // Reference model sampled mid-cycle once everything has settled
    // ------------------------------------------------------------------------

    always @(negedge clk) begin
        gear_word_u exp_word;
        logic       exp_rdy;
        if (reset) begin
            expect_q.delete();
            model_index = 4'd0;
            stall_q     = 1'b0;
            ref_digit   = 0;
            ref_cnt     = 0;
        end else begin
            checks++;
            if (!$onehot(digit)) begin
                errors++;
                $display("FAIL digit: got %h, expected a one-hot value at %0t", digit, $time);
            end else begin
                check_value("digit", digit, `GEARBOX_DIGITS'(1) << ref_digit);
                check_value("abcdefgh", abcdefgh, expected_segments());
            end

            // Select moves up one digit per refresh period and wraps after the top
            if (ref_cnt == `GEARBOX_REFRESH - 1) begin
                ref_cnt   = 0;
                ref_digit = (ref_digit + 1) % `GEARBOX_DIGITS;
            end else begin
                ref_cnt++;
            end

            // EMPTY takes a word, HI refuses, LO takes one as the low nibble leaves
            exp_rdy = (expect_q.size() == 0) || (expect_q.size() == 1 && down_rdy);
            check_value("up_rdy", up_rdy, exp_rdy);
            check_value("down_vld", down_vld, expect_q.size() != 0);
            if (down_vld && expect_q.size() != 0)
                check_value("down_data", down_data, expect_q[0]);
            if (stall_q) begin
                check_value("down_vld", down_vld, 1'b1);
                check_value("down_data", down_data, stall_data);
            end

            if (down_vld && down_rdy && expect_q.size() != 0)
                void'(expect_q.pop_front());
            if (up_vld && up_rdy) begin
                exp_word.nib.hi = pattern_table[model_index];
                exp_word.nib.lo = pattern_table[model_index ^ 4'd2];
                check_value("up_data", up_data.word, exp_word.word);
                expect_q.push_back(exp_word.nib.hi);
                expect_q.push_back(exp_word.nib.lo);
                model_index = model_index + 4'd1;
                words++;
            end

            stall_q    = down_vld && !down_rdy;
            stall_data = down_data;
        end
        pending = expect_q.size();
    end

endmodule

`default_nettype wire

/* gearbox_top.sv */
`default_nettype none

`include "gearbox_cfg.svh"

module gearbox_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        up_vld_in,
    input  logic                        down_rdy,
    output logic                        up_vld,
    output logic                        up_rdy,
    output logic [2*`GEARBOX_WIDTH-1:0] up_data,
    output logic                        down_vld,
    output logic [`GEARBOX_WIDTH-1:0]   down_data,
    output logic [7:0]                  abcdefgh,
    output logic [`GEARBOX_DIGITS-1:0]  digit
);

    import gearbox_pkg::*;

    // Control to datapath
    logic  load;
    half_e half;

    // ------------------------------------------------------------------------
    // Upstream word source
    // ------------------------------------------------------------------------

    pattern_source i_source (
        .clk       (clk),
        .reset     (reset),
        .up_vld_in (up_vld_in),
        .up_rdy    (up_rdy),
        .up_vld    (up_vld),
        .up_data   (up_data)
    );

    // ------------------------------------------------------------------------
    // 2-to-1 gearbox
    // ------------------------------------------------------------------------

    gearbox_ctrl i_ctrl (
        .clk      (clk),
        .reset    (reset),
        .up_vld   (up_vld),
        .up_rdy   (up_rdy),
        .down_rdy (down_rdy),
        .down_vld (down_vld),
        .load     (load),
        .half     (half)
    );

    gearbox_datapath i_datapath (
        .clk       (clk),
        .reset     (reset),
        .load      (load),
        .half      (half),
        .up_data   (up_data),
        .down_data (down_data)
    );

    // ------------------------------------------------------------------------
    // Display
    // ------------------------------------------------------------------------

    display_scan_timer i_timer (
        .clk   (clk),
        .reset (reset),
        .digit (digit)
    );

    seven_segment_display i_display (
        .digit     (digit),
        .up_vld    (up_vld),
        .up_data   (up_data),
        .down_vld  (down_vld),
        .down_data (down_data),
        .abcdefgh  (abcdefgh)
    );

endmodule

`default_nettype wire

/* seven_segment_display.sv */
`default_nettype none

`include "gearbox_cfg.svh"

module seven_segment_display (
    input  logic [`GEARBOX_DIGITS-1:0] digit,
    input  logic                       up_vld,
    input  gearbox_pkg::gear_word_u    up_data,
    input  logic                       down_vld,
    input  logic [`GEARBOX_WIDTH-1:0]  down_data,
    output logic [7:0]                 abcdefgh
);

    import gearbox_pkg::*;

    localparam int SEL_W = $clog2(`GEARBOX_DIGITS);

    logic [SEL_W-1:0]          sel;
    logic [`GEARBOX_WIDTH-1:0] nibble;
    logic                      dot;
    logic                      blank;
    logic [7:0]                code;

    // ------------------------------------------------------------------------
    // Selected digit position
    // ------------------------------------------------------------------------

    always_comb begin
        sel = '0;
        for (int i = 0; i < `GEARBOX_DIGITS; i++) begin
            if (digit[i])
                sel = SEL_W'(i);
        end
    end

    // ------------------------------------------------------------------------
    // Digit contents
    // ------------------------------------------------------------------------

    always_comb begin
        nibble = '0;
        dot    = 1'b0;
        blank  = 1'b0;
        case (sel)
            7: begin
                nibble = up_data.nib.hi;
                dot    = up_vld;
            end
            6: begin
                nibble = up_data.nib.lo;
                dot    = up_vld;
            end
            // Separator between upstream and downstream
            1: begin
                blank = 1'b1;
            end
            // Downstream nibble only while it is valid
            0: begin
                nibble = down_data;
                blank  = ~down_vld;
            end
            // Digits 5 to 2 show a plain zero
            default: begin
                nibble = '0;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // Segment encoding
    // ------------------------------------------------------------------------

    assign code = segment_table[nibble];

    always_comb begin
        if (blank)
            abcdefgh = 8'b0000_0000;
        else
            abcdefgh = {code[7:1], dot};
    end

endmodule

`default_nettype wire

/* display_scan_timer.sv */
`default_nettype none

`include "gearbox_cfg.svh"

module display_scan_timer (
    input  logic                       clk,
    input  logic                       reset,
    output logic [`GEARBOX_DIGITS-1:0] digit
);

    // Extra count bit keeps the width nonzero for a refresh of one
    localparam int CNT_W = $clog2(`GEARBOX_REFRESH + 1);

    logic [CNT_W-1:0] refresh_cnt;
    logic             step;

    assign step = (refresh_cnt == CNT_W'(`GEARBOX_REFRESH - 1));

    // Cycles spent on the current digit
    always_ff @(posedge clk) begin
        if (reset)
            refresh_cnt <= '0;
        else if (step)
            refresh_cnt <= '0;
        else
            refresh_cnt <= refresh_cnt + 1'b1;
    end

    // One-hot select, rotates toward the top digit and wraps to digit 0
    always_ff @(posedge clk) begin
        if (reset)
            digit <= `GEARBOX_DIGITS'(1);
        else if (step)
            digit <= {digit[`GEARBOX_DIGITS-2:0], digit[`GEARBOX_DIGITS-1]};
    end

endmodule

`default_nettype wire

/* gearbox_datapath.sv */
`default_nettype none

`include "gearbox_cfg.svh"

module gearbox_datapath (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      load,
    input  gearbox_pkg::half_e        half,
    input  gearbox_pkg::gear_word_u   up_data,
    output logic [`GEARBOX_WIDTH-1:0] down_data
);

    import gearbox_pkg::*;

    // ------------------------------------------------------------------------
    // Word register
    // ------------------------------------------------------------------------

    gear_word_u word_q;

    // Captured on every upstream transfer
    always_ff @(posedge clk) begin
        if (reset)
            word_q <= '0;
        else if (load)
            word_q <= up_data;
    end

    // ------------------------------------------------------------------------
    // Half selector
    // ------------------------------------------------------------------------

    always_comb begin
        if (half == HI)
            down_data = word_q.nib.hi;
        else
            down_data = word_q.nib.lo;
    end

    // Holds under back-pressure because neither load nor half moves
    // until the downstream side accepts

endmodule

`default_nettype wire

/* gearbox_ctrl.sv */
`default_nettype none

module gearbox_ctrl (
    input  logic               clk,
    input  logic               reset,
    input  logic               up_vld,
    output logic               up_rdy,
    input  logic               down_rdy,
    output logic               down_vld,
    output logic               load,
    output gearbox_pkg::half_e half
);

    import gearbox_pkg::*;

    // ------------------------------------------------------------------------
    // State
    // ------------------------------------------------------------------------

    // EMPTY when full_q is low, otherwise HI or LO as held in half_q
    logic  full_q;
    half_e half_q;

    logic  in_lo;
    logic  up_xfer;
    logic  down_xfer;

    assign in_lo = full_q & (half_q == LO);

    // ------------------------------------------------------------------------
    // Handshakes
    // ------------------------------------------------------------------------

    // EMPTY takes a word at once, LO takes one as the low nibble leaves
    assign up_rdy    = ~full_q | (in_lo & down_rdy);
    assign up_xfer   = up_vld & up_rdy;
    assign down_xfer = full_q & down_rdy;

    // ------------------------------------------------------------------------
    // Transitions
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            full_q <= 1'b0;
            half_q <= HI;
        end else if (up_xfer) begin
            // New word, high nibble goes first
            full_q <= 1'b1;
            half_q <= HI;
        end else if (down_xfer) begin
            if (half_q == HI) begin
                half_q <= LO;
            end else begin
                // Low nibble gone and nothing new arrived
                full_q <= 1'b0;
                half_q <= HI;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------------------

    assign down_vld = full_q;
    assign load     = up_xfer;
    assign half     = half_q;

endmodule

`default_nettype wire

/* pattern_source.sv */
`default_nettype none

`include "gearbox_cfg.svh"

module pattern_source (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   up_vld_in,
    input  logic                   up_rdy,
    output logic                   up_vld,
    output gearbox_pkg::gear_word_u up_data
);

    import gearbox_pkg::*;

    // ------------------------------------------------------------------------
    // Index counter
    // ------------------------------------------------------------------------

    logic [3:0] index;
    logic [3:0] index_pair;
    logic       up_xfer;

    assign up_xfer = up_vld & up_rdy;

    // Moves to the next table entry once the current word is taken
    always_ff @(posedge clk) begin
        if (reset)
            index <= 4'd0;
        else if (up_xfer)
            index <= index + 4'd1;
    end

    // ------------------------------------------------------------------------
    // Word formation
    // ------------------------------------------------------------------------

    // Partner entry two places away in the table
    assign index_pair = index ^ 4'd2;

    always_comb begin
        up_data.nib.hi = pattern_table[index];
        up_data.nib.lo = pattern_table[index_pair];
    end

    // Valid comes straight from the outside request
    assign up_vld = up_vld_in;

    // The word only changes after a transfer, so it holds while valid
    // waits for ready

endmodule

`default_nettype wire

/* gearbox_pkg.sv */
`default_nettype none

`include "gearbox_cfg.svh"

package gearbox_pkg;

    // Two nibbles of a gearbox word, upper half sent first
    typedef struct packed {
        logic [`GEARBOX_WIDTH-1:0] hi;
        logic [`GEARBOX_WIDTH-1:0] lo;
    } gear_nib_s;

    // Same word seen as a raw byte or as a nibble pair
    typedef union packed {
        logic [2*`GEARBOX_WIDTH-1:0] word;
        gear_nib_s                   nib;
    } gear_word_u;

    // Which half of the word the datapath presents downstream
    typedef enum logic {
        HI,
        LO
    } half_e;

    // Fixed permutation walked by the pattern source
    localparam logic [`GEARBOX_WIDTH-1:0] pattern_table [0:15] = '{
        4'h2, 4'h6, 4'hd, 4'hb, 4'h7, 4'he, 4'hc, 4'h4,
        4'h1, 4'h0, 4'h9, 4'ha, 4'hf, 4'h5, 4'h8, 4'h3
    };

    // Hex digit codes, segment a in bit 7, dot in bit 0 left clear
    localparam logic [7:0] segment_table [0:15] = '{
        8'hfc, 8'h60, 8'hda, 8'hf2, 8'h66, 8'hb6, 8'hbe, 8'he0,
        8'hfe, 8'hf6, 8'hee, 8'h3e, 8'h9c, 8'h7a, 8'h9e, 8'h8e
    };

endpackage

`default_nettype wire

/* gearbox_cfg.svh */
`ifndef GEARBOX_CFG_SVH
`define GEARBOX_CFG_SVH

// ------------------------------------------------------------------------
// Gearbox geometry
// ------------------------------------------------------------------------

// Width of one downstream nibble, the upstream word is twice this
`define GEARBOX_WIDTH 4

// ------------------------------------------------------------------------
// Display geometry and scan rate
// ------------------------------------------------------------------------

// Digits on the multiplexed seven-segment display
`define GEARBOX_DIGITS 8

// Clock cycles each digit stays selected, kept small for short runs
`define GEARBOX_REFRESH 4

`endif
